/* hdl/uart_pkg.sv */
// Shared UART types, Wishbone bus structs, TX state enum, register map
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;    // One data byte
    typedef logic [1:0] wb_addr_t;      // Register address
    typedef logic [7:0] wb_data_t;      // Wishbone data bus
    typedef logic [4:0] fifo_level_t;   // FIFO occupancy, depth up to 16
    typedef logic [9:0] frame_t;        // Stop, data, start; LSB goes first

    // Master to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LOAD,
        TX_SHIFT
    } tx_state_e;

    localparam wb_addr_t ADDR_TXDATA = 2'd0;
    localparam wb_addr_t ADDR_STATUS = 2'd1;

    // Status byte layout, bits 7:3 carry the FIFO level
    localparam int STATUS_FULL_BIT  = 0;
    localparam int STATUS_EMPTY_BIT = 1;
    localparam int STATUS_BUSY_BIT  = 2;

endpackage

`default_nettype wire

/* hdl/baud_tick_gen.sv */
// Bit-rate tick generator, one-cycle pulse every CLKS_PER_BIT cycles while enabled
`timescale 1ns/10ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic tick_en,  // High while a frame is on the line
    output logic      tick      // Marks the last cycle of a bit
);

    // Counter needs at least one bit even for CLKS_PER_BIT of 1
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] cnt;

    // Down-counter, sits at the reload value while disabled
    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt <= RELOAD;
        end else if (!tick_en) begin
            cnt <= RELOAD;             // Next enable starts a full bit period
        end else if (cnt == '0) begin
            cnt <= RELOAD;             // Reload at each tick
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // First tick lands CLKS_PER_BIT cycles after enable rises
    assign tick = tick_en && (cnt == '0);

endmodule

`default_nettype wire

/* hdl/tx_fifo.sv */
// Synchronous transmit FIFO, first-word fall-through, full/empty/level flags
`timescale 1ns/10ps
`default_nettype none

module tx_fifo import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 4        // Power of two, 2 to 16
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        push,
    input  wire uart_byte_t  push_data,
    input  wire logic        pop,
    output uart_byte_t       pop_data,   // Head entry, valid while not empty
    output logic             full,
    output logic             empty,
    output fifo_level_t      level
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam fifo_level_t DEPTH_L = fifo_level_t'(FIFO_DEPTH);

    uart_byte_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Guarded by the flags, so a stray request cannot corrupt the count
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Byte storage, written at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;        // Both or neither, count holds
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];             // Fall-through read
    assign full     = (level == DEPTH_L);
    assign empty    = (level == '0);

    // Consumer must look at empty before popping
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst)
        pop |-> !empty)
        else $error("tx_fifo pop while empty");

endmodule

`default_nettype wire

/* hdl/wb_uart_regs.sv */
// Wishbone classic register block, TX data push and status readback
`timescale 1ns/10ps
`default_nettype none

module wb_uart_regs import uart_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire wb_req_t     wb_req,
    output wb_rsp_t          wb_rsp,
    output logic             push,        // One per accepted data write
    output uart_byte_t       push_data,
    input  wire logic        full,
    input  wire logic        empty,
    input  wire fifo_level_t level,
    input  wire logic        busy         // Transmitter has a frame in flight
);

    logic     req;          // Cycle open and not yet answered
    logic     wr_data;      // Write to the TX data register
    logic     ack_d;
    wb_data_t status;
    wb_data_t rd_data;

    // No new request is taken in the ack cycle, the master still holds it there
    assign req     = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wr_data = req && wb_req.we && (wb_req.adr == ADDR_TXDATA);

    // Back-pressure, data writes wait for room in the FIFO
    assign push      = wr_data && !full;
    assign push_data = wb_req.dat;
    assign ack_d     = req && (!wr_data || !full);

    always_comb begin
        status                   = '0;
        status[STATUS_FULL_BIT]  = full;
        status[STATUS_EMPTY_BIT] = empty;
        status[STATUS_BUSY_BIT]  = busy;
        status[7:3]              = level;   // 5-bit level, tops out at 16
    end

    // Only the status register reads back
    assign rd_data = (!wb_req.we && wb_req.adr == ADDR_STATUS) ? status : '0;

    // Registered response, ack for exactly one cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_rsp.ack <= 1'b0;
            wb_rsp.dat <= '0;
        end else begin
            wb_rsp.ack <= ack_d;
            if (ack_d) wb_rsp.dat <= rd_data;
        end
    end

    // Ack drops between back-to-back transfers
    a_ack_single: assert property (@(posedge clk) disable iff (!rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("wb ack held for two cycles");

    // Push into a full FIFO would drop a byte
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        push |-> !full)
        else $error("push while FIFO full");

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
// UART 8N1 transmit FSM with frame shift register and bit counter
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    output logic            pop,        // Take head byte from FIFO
    input  wire uart_byte_t pop_data,
    input  wire logic       empty,
    output logic            tick_en,    // Runs baud counter during shift
    input  wire logic       tick,
    output logic            tx,         // Serial line, idles high
    output logic            busy
);

    localparam logic [3:0] FRAME_BITS = 4'd10;     // Start, 8 data, stop

    tx_state_e  state;
    tx_state_e  state_nxt;
    frame_t     frame_q;        // Shifts right, bit 0 on the line
    logic [3:0] bit_cnt;        // Bits finished in this frame
    logic       last_bit;

    assign last_bit = (bit_cnt == FRAME_BITS - 1'b1);

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            TX_IDLE: begin
                if (!empty) state_nxt = TX_LOAD;
            end
            TX_LOAD: begin
                state_nxt = TX_SHIFT;
            end
            TX_SHIFT: begin
                if (tick && last_bit) state_nxt = TX_IDLE;   // Stop bit done
            end
            default: state_nxt = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= TX_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Frame register, loaded during the pop cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            frame_q <= {1'b1, pop_data, 1'b0};
        end else if (state == TX_SHIFT && tick) begin
            frame_q <= {1'b1, frame_q[9:1]};            // Fill with idle level
        end
    end

    // Bit counter, cleared in TX_LOAD
    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
        end else if (state == TX_LOAD) begin
            bit_cnt <= '0;
        end else if (state == TX_SHIFT && tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign pop     = (state == TX_IDLE) && !empty;
    assign tick_en = (state == TX_SHIFT);
    assign tx      = (state == TX_SHIFT) ? frame_q[0] : 1'b1;
    assign busy    = (state != TX_IDLE);

    // Line idles high between frames
    a_idle_high: assert property (@(posedge clk) disable iff (!rst)
        (state == TX_IDLE) |-> tx)
        else $error("tx low while idle");

    // Counter stops at the end of the stop bit
    a_bit_cnt_max: assert property (@(posedge clk) disable iff (!rst)
        bit_cnt <= FRAME_BITS)
        else $error("bit counter past frame length");

endmodule

`default_nettype wire

/* hdl/uart_tx_top.sv */
// Top level of the Wishbone UART transmitter, regs + FIFO + tick gen + serializer
`timescale 1ns/10ps
`default_nettype none

module uart_tx_top import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter int FIFO_DEPTH   = 4
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp,
    output logic         tx
);

    // Register block to FIFO
    logic        push;
    uart_byte_t  push_data;
    // FIFO to transmitter
    logic        pop;
    uart_byte_t  pop_data;
    logic        full;
    logic        empty;
    fifo_level_t level;
    // Transmitter and tick generator
    logic        tick_en;
    logic        tick;
    logic        busy;

    wb_uart_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .empty     (empty),
        .level     (level),
        .busy      (busy)
    );

    tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty),
        .level     (level)
    );

    baud_tick_gen #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tick (
        .clk     (clk),
        .rst     (rst),
        .tick_en (tick_en),
        .tick    (tick)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty),
        .tick_en  (tick_en),
        .tick     (tick),
        .tx       (tx),
        .busy     (busy)
    );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
// Testbench clock and reset source, 8 ns clock, active-low reset for 4 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_uart_tx.sv */
// Testbench for the Wishbone UART transmitter: bus tasks, line decoder, byte model, checks
`timescale 1ns/10ps
`default_nettype none

module tb_uart_tx import uart_pkg::*; ();

    localparam int CLKS_PER_BIT   = 8;
    localparam int FIFO_DEPTH     = 4;
    localparam int BURST_LEN      = 40;
    localparam int TOTAL_BYTES    = 1 + BURST_LEN;         // Single frame plus burst
    localparam int FRAME_CYCLES   = 2 + 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = (TOTAL_BYTES + 4) * FRAME_CYCLES + 200;

    logic       clk;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       tx;

    uart_byte_t exp_q[$];       // Bytes whose writes were acked, oldest first
    integer     seed;
    int         err_count;
    int         frames_seen;    // Complete frames decoded on tx
    int         cycle_cnt;
    int         tests_ok;
    int         tests_bad;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    uart_tx_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_uart_tx_top (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .tx     (tx)
    );

    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERR at %0t ns: %s got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERR at %0t ns: %s got %08b, expected %08b", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERR at %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Status byte as the register map defines it, level saturates at 31
    function automatic wb_data_t expect_status(input logic f, input logic e, input logic b,
                                               input int lvl);
        wb_data_t s;
        int       sat;
        sat                 = (lvl > 31) ? 31 : lvl;
        s                   = '0;
        s[STATUS_FULL_BIT]  = f;
        s[STATUS_EMPTY_BIT] = e;
        s[STATUS_BUSY_BIT]  = b;
        s[7:3]              = 5'(sat);
        return s;
    endfunction

    // Classic write, called on a falling edge, returns cycles until ack
    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, output int waits);
        waits      = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge clk);
            waits++;
        end while (!wb_rsp.ack);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        if (adr == ADDR_TXDATA) exp_q.push_back(dat);    // Only data writes make frames
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        do @(negedge clk); while (!wb_rsp.ack);
        dat        = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic drain_model;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAILED with %0d errors", num, name, err_count - errs_before);
        end
    endtask

    // Serial decoder, mid-bit sampling on falling clock edges
    initial begin
        uart_byte_t rx;
        wait (rst === 1'b1);
        forever begin
            @(negedge tx);
            if (exp_q.size() == 0) begin
                err_count++;
                $display("Frame started on tx at %0t ns with no byte written", $time);
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_line(tx, 1'b0, "start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx[i] = tx;                                // LSB first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_line(tx, 1'b1, "stop bit");
            frames_seen++;
            if (exp_q.size() != 0) check_byte(rx, exp_q.pop_front(), "decoded byte");
        end
    end

    // Watchdog sized from the byte count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles, a handshake or frame never came",
                     TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        wb_data_t   st;
        uart_byte_t b;
        int         waits;
        int         stalls;
        int         errs;
        int         frames0;
        seed        = 33252;
        wb_req      = '0;
        err_count   = 0;
        frames_seen = 0;
        cycle_cnt   = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        wait (rst === 1'b1);
        @(negedge clk);

        // 1: idle line and reset status
        errs = err_count;
        for (int i = 0; i < 20; i++) begin
            check_line(tx, 1'b1, "idle line after reset");
            @(negedge clk);
        end
        wb_read(ADDR_STATUS, st);
        check_status(st, expect_status(1'b0, 1'b1, 1'b0, 0), "status after reset");
        report_test(1, "reset state", errs);

        // 2: one byte, start bit length checked, LSB forced high to see the edge
        errs    = err_count;
        frames0 = frames_seen;
        b       = uart_byte_t'($random(seed)) | 8'h01;
        wb_write(ADDR_TXDATA, b, waits);
        @(negedge tx);
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_line(tx, 1'b0, "last cycle of start bit");
        @(negedge clk);
        check_line(tx, 1'b1, "first cycle of data bit 0");
        drain_model();
        if (frames_seen != frames0 + 1) begin
            err_count++;
            $display("Single write gave %0d frames instead of one", frames_seen - frames0);
        end
        report_test(2, "single frame", errs);

        // 3: back-to-back writes, far past the FIFO depth
        errs    = err_count;
        frames0 = frames_seen;
        stalls  = 0;
        for (int i = 0; i < BURST_LEN; i++) begin
            b = uart_byte_t'($random(seed));
            wb_write(ADDR_TXDATA, b, waits);
            if (waits > 2) stalls++;                   // Two cycles is the unstalled pace
        end
        if (stalls == 0) begin
            err_count++;
            $display("No write stalled during the burst, back-pressure never showed");
        end
        wb_read(ADDR_STATUS, st);
        check_status(st, expect_status(1'b1, 1'b0, 1'b1, FIFO_DEPTH), "status after burst");
        report_test(3, "burst with back-pressure", errs);

        // 4: busy while draining, then idle status
        errs = err_count;
        wb_read(ADDR_STATUS, st);
        check_line(st[STATUS_BUSY_BIT], 1'b1, "busy bit during burst");
        drain_model();
        if (frames_seen != frames0 + BURST_LEN) begin
            err_count++;
            $display("Burst gave %0d frames instead of %0d", frames_seen - frames0, BURST_LEN);
        end
        repeat (2 * CLKS_PER_BIT) @(negedge clk);      // Rest of stop bit plus one idle bit
        check_line(tx, 1'b1, "idle line after burst");
        wb_read(ADDR_STATUS, st);
        check_status(st, expect_status(1'b0, 1'b1, 1'b0, 0), "status after drain");
        report_test(4, "drain and idle status", errs);

        // 5: writes outside the data register make no frame
        errs    = err_count;
        frames0 = frames_seen;
        wb_write(ADDR_STATUS, wb_data_t'($random(seed)), waits);
        wb_write(2'd2, wb_data_t'($random(seed)), waits);
        wb_write(2'd3, wb_data_t'($random(seed)), waits);
        repeat (FRAME_CYCLES) @(negedge clk);
        if (frames_seen != frames0) begin
            err_count++;
            $display("Writes to non-data addresses produced %0d frames", frames_seen - frames0);
        end
        check_line(tx, 1'b1, "line after ignored writes");
        wb_read(2'd2, st);
        check_status(st, 8'h00, "read of unused address 2");
        wb_read(2'd3, st);
        check_status(st, 8'h00, "read of unused address 3");
        wb_read(ADDR_STATUS, st);
        check_status(st, expect_status(1'b0, 1'b1, 1'b0, 0), "status after ignored writes");
        report_test(5, "unused addresses", errs);

        $display("Tests: %0d ok, %0d failed, %0d errors in total", tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/uart_pkg.sv
hdl/baud_tick_gen.sv
hdl/tx_fifo.sv
hdl/wb_uart_regs.sv
hdl/uart_tx.sv
hdl/uart_tx_top.sv
sim/tb_clk_gen.sv
sim/tb_uart_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build the UART transmitter testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_uart_tx \
    -f flist.f \
    --Mdir obj_dir -o tb_uart_tx_sim

./obj_dir/tb_uart_tx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "run_sim: pass message found in sim.log"
else
    echo "run_sim: pass message missing from sim.log"
    exit 1
fi
